//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_cpu -f verilog.f
	./obj_dir/Vtb_cpu +verilator+error+limit+100

clean:
	rm -rf obj_dir

//--- src/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_isa_pkg::*; (
	cpu_alu_if.alu alu
);
	data_t res;
	data_t flags;
	logic carry;
	logic aux;
	logic cin;
	logic [4:0] nib;

	assign cin = (alu.op == ALU_ADC || alu.op == ALU_SBB) ? alu.carry_in : 1'b0;

	always_comb begin
		res = alu.operand;
		carry = 1'b0;
		aux = 1'b0;
		nib = '0;
		case (alu.op)
			ALU_ADD, ALU_ADC: begin
				{carry, res} = {1'b0, alu.acc} + {1'b0, alu.operand} + {8'd0, cin};
				nib = {1'b0, alu.acc[3:0]} + {1'b0, alu.operand[3:0]} + {4'd0, cin};
				aux = nib[4];
			end
			ALU_SUB, ALU_SBB, ALU_CMP: begin
				{carry, res} = {1'b0, alu.acc} - {1'b0, alu.operand} - {8'd0, cin};
				nib = {1'b0, alu.acc[3:0]} - {1'b0, alu.operand[3:0]} - {4'd0, cin};
				aux = ~nib[4]; // set when the low nibble needs no borrow.
			end
			ALU_AND: begin
				res = alu.acc & alu.operand;
				aux = alu.acc[3] | alu.operand[3];
			end
			ALU_XOR:
				res = alu.acc ^ alu.operand;
			ALU_OR:
				res = alu.acc | alu.operand;
			ALU_INC: begin
				res = alu.operand + 8'd1;
				aux = alu.operand[3:0] == 4'hf;
			end
			ALU_DEC: begin
				res = alu.operand - 8'd1;
				aux = alu.operand[3:0] != 4'h0;
			end
			default:
				res = alu.operand;
		endcase
	end

	// flags land in their PSR positions.
	always_comb begin
		flags = PSR_FIXED_ONES;
		flags[FLAG_S] = res[7];
		flags[FLAG_Z] = res == 8'h00;
		flags[FLAG_AC] = aux;
		flags[FLAG_P] = ~^res; // even parity.
		flags[FLAG_C] = carry;
	end

	assign alu.result = res;
	assign alu.flags = flags;

endmodule

//--- src/cpu_alu_if.sv
`timescale 1ns/1ps

interface cpu_alu_if import cpu_isa_pkg::*; ();
	data_t acc;
	data_t operand;
	logic carry_in;
	alu_op_t op;
	data_t result;
	data_t flags;

	modport dp (
		output acc, operand, carry_in, op,
		input result, flags
	);

	modport alu (
		input acc, operand, carry_in, op,
		output result, flags
	);

endinterface

//--- src/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();
	logic step; // the current bus cycle ends at this edge.
	db_sel_t db_src;
	db_sel_t db_dst;
	alu_op_t alu_op;
	data_t set_flags;
	logic pc_inc;
	logic pc_load;
	addr_sel_t addr_sel;
	data_t psr;

	modport seq (
		output step, db_src, db_dst, alu_op, set_flags,
		output pc_inc, pc_load, addr_sel,
		input psr
	);

	modport dp (
		input step, db_src, db_dst, alu_op, set_flags,
		input pc_inc, pc_load, addr_sel,
		output psr
	);

endinterface

//--- src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	typedef enum logic [4:0] {
		ST_FETCH,
		ST_DECODE,
		ST_MOV,
		ST_MVI0,
		ST_MVI1,
		ST_ALU0,
		ST_ALU1,
		ST_INRDCR0,
		ST_INRDCR1,
		ST_LXI0,
		ST_LXI1,
		ST_JMP0,
		ST_JMP1,
		ST_DIRECT0,
		ST_DIRECT1,
		ST_DIRECT2,
		ST_HALT
	} state_t;

	// codes 8 to 15 follow the 8080 register field, so M sits on the memory code.
	typedef enum logic [4:0] {
		DB_NONE = 5'd0,
		DB_OPND = 5'd1,
		DB_ALL = 5'd2,
		DB_ALH = 5'd3,
		DB_PSR = 5'd6,
		DB_ALU = 5'd7,
		DB_B = 5'd8,
		DB_C = 5'd9,
		DB_D = 5'd10,
		DB_E = 5'd11,
		DB_H = 5'd12,
		DB_L = 5'd13,
		DB_MEM = 5'd14,
		DB_A = 5'd15
	} db_sel_t;

	typedef enum logic [1:0] {
		ADDR_PC = 2'd0,
		ADDR_HL = 2'd1,
		ADDR_AL = 2'd2
	} addr_sel_t;

endpackage

//--- src/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	cpu_ctrl_if.dp ctrl,
	input data_t memory_rdata,
	output addr_t memory_addr,
	output data_t memory_wdata
);
	data_t reg_a;
	data_t reg_b;
	data_t reg_c;
	data_t reg_d;
	data_t reg_e;
	data_t reg_h;
	data_t reg_l;
	data_t opnd;
	data_t psr;
	data_t psr_next;
	data_t db;
	addr_t pc;
	addr_t al;
	addr_t al_next;

	cpu_alu_if alu_bus ();

	cpu_alu alu_inst (
		.alu(alu_bus)
	);

	assign alu_bus.acc = reg_a;
	assign alu_bus.operand = opnd;
	assign alu_bus.carry_in = psr[FLAG_C];
	assign alu_bus.op = ctrl.alu_op;

	always_comb begin
		case (ctrl.db_src)
			DB_A: db = reg_a;
			DB_B: db = reg_b;
			DB_C: db = reg_c;
			DB_D: db = reg_d;
			DB_E: db = reg_e;
			DB_H: db = reg_h;
			DB_L: db = reg_l;
			DB_OPND: db = opnd;
			DB_PSR: db = psr;
			DB_MEM: db = memory_rdata;
			DB_ALL: db = al[7:0];
			DB_ALH: db = al[15:8];
			DB_ALU: db = alu_bus.result;
			default: db = '0;
		endcase
	end

	// a jump takes the high byte straight off the bus in the same cycle.
	always_comb begin
		al_next = al;
		if (ctrl.db_dst == DB_ALL)
			al_next[7:0] = db;
		if (ctrl.db_dst == DB_ALH)
			al_next[15:8] = db;
	end

	always_comb begin
		psr_next = (psr & ~ctrl.set_flags) | (alu_bus.flags & ctrl.set_flags);
		if (ctrl.db_dst == DB_PSR)
			psr_next = db;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			psr <= PSR_FIXED_ONES;
		end else if (ctrl.step) begin
			if (ctrl.pc_load)
				pc <= al_next;
			else if (ctrl.pc_inc)
				pc <= pc + 16'd1;
			psr <= (psr_next & ~PSR_FIXED_ZEROS) | PSR_FIXED_ONES;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.step) begin
			al <= al_next;
			case (ctrl.db_dst)
				DB_A: reg_a <= db;
				DB_B: reg_b <= db;
				DB_C: reg_c <= db;
				DB_D: reg_d <= db;
				DB_E: reg_e <= db;
				DB_H: reg_h <= db;
				DB_L: reg_l <= db;
				DB_OPND: opnd <= db;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (ctrl.addr_sel)
			ADDR_HL: memory_addr = {reg_h, reg_l};
			ADDR_AL: memory_addr = al;
			default: memory_addr = pc;
		endcase
	end

	assign memory_wdata = db;
	assign ctrl.psr = psr;

endmodule

//--- src/cpu_isa_pkg.sv
package cpu_isa_pkg;

	typedef logic [7:0] data_t;
	typedef logic [15:0] addr_t;

	typedef struct packed {
		logic [1:0] group;
		logic [2:0] dst;
		logic [2:0] src;
	} move_view_t;

	typedef struct packed {
		logic [1:0] group;
		logic [1:0] pair;
		logic [3:0] low;
	} pair_view_t;

	// one instruction byte, read as register fields or as a register pair.
	typedef union packed {
		move_view_t mv;
		pair_view_t pr;
	} opcode_t;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_ADC = 5'd1,
		ALU_SUB = 5'd2,
		ALU_SBB = 5'd3,
		ALU_AND = 5'd4,
		ALU_XOR = 5'd5,
		ALU_OR = 5'd6,
		ALU_CMP = 5'd7,
		ALU_INC = 5'd16,
		ALU_DEC = 5'd17,
		ALU_PASS = 5'd31
	} alu_op_t;

	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_AC = 4;
	localparam int FLAG_P = 2;
	localparam int FLAG_C = 0;
	localparam data_t PSR_FIXED_ONES = 8'h02; // bit 1 always reads one.
	localparam data_t PSR_FIXED_ZEROS = 8'h28;

	localparam logic [2:0] reg_m_code = 3'b110;

	// condition field of Jcc, bits 5 to 3.
	localparam logic [2:0] COND_NZ = 3'd0;
	localparam logic [2:0] COND_Z = 3'd1;
	localparam logic [2:0] COND_NC = 3'd2;
	localparam logic [2:0] COND_C = 3'd3;
	localparam logic [2:0] COND_PO = 3'd4;
	localparam logic [2:0] COND_PE = 3'd5;
	localparam logic [2:0] COND_P = 3'd6;
	localparam logic [2:0] COND_M = 3'd7;

	localparam data_t OP_HLT = 8'h76;
	localparam data_t OP_JMP = 8'hc3;
	localparam data_t OP_LDA = 8'h3a;
	localparam data_t OP_STA = 8'h32;

endpackage

//--- src/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	cpu_ctrl_if.seq ctrl,
	input data_t memory_rdata,
	input logic memory_done,
	output logic memory_read,
	output logic memory_write,
	output logic cpu_fetch,
	output logic cpu_halted
);
	opcode_t ir;
	state_t state;
	state_t next_state;
	alu_op_t alu_grp;
	logic i_hlt, i_mov, i_alu, i_alui, i_mvi, i_inr, i_dcr;
	logic i_lxi, i_lda, i_sta, i_jmp, i_jcc;
	logic src_m, dst_m, cond, taken;

	// register field to bus code; field 6 falls on DB_MEM.
	function automatic db_sel_t reg_code(input logic [2:0] field);
		return db_sel_t'({2'b01, field});
	endfunction

	assign i_hlt = ir == OP_HLT;
	assign i_mov = ir.mv.group == 2'b01 && !i_hlt;
	assign i_alu = ir.mv.group == 2'b10;
	assign i_alui = ir.mv.group == 2'b11 && ir.mv.src == 3'b110;
	assign i_mvi = ir.mv.group == 2'b00 && ir.mv.src == 3'b110;
	assign i_inr = ir.mv.group == 2'b00 && ir.mv.src == 3'b100;
	assign i_dcr = ir.mv.group == 2'b00 && ir.mv.src == 3'b101;
	assign i_lxi = ir.pr.group == 2'b00 && ir.pr.low == 4'b0001 && ir.pr.pair != 2'b11;
	assign i_lda = ir == OP_LDA;
	assign i_sta = ir == OP_STA;
	assign i_jmp = ir == OP_JMP;
	assign i_jcc = ir.mv.group == 2'b11 && ir.mv.src == 3'b010;
	assign src_m = ir.mv.src == reg_m_code;
	assign dst_m = ir.mv.dst == reg_m_code;
	assign alu_grp = alu_op_t'({2'b00, ir.mv.dst});

	always_comb begin
		case (ir.mv.dst)
			COND_NZ: cond = !ctrl.psr[FLAG_Z];
			COND_Z: cond = ctrl.psr[FLAG_Z];
			COND_NC: cond = !ctrl.psr[FLAG_C];
			COND_C: cond = ctrl.psr[FLAG_C];
			COND_PO: cond = !ctrl.psr[FLAG_P];
			COND_PE: cond = ctrl.psr[FLAG_P];
			COND_P: cond = !ctrl.psr[FLAG_S];
			COND_M: cond = ctrl.psr[FLAG_S];
			default: cond = 1'b0;
		endcase
	end
	assign taken = i_jmp || cond;

	always_comb begin
		next_state = ST_FETCH;
		case (state)
			ST_FETCH: next_state = ST_DECODE;
			ST_DECODE: begin
				if (i_hlt)
					next_state = ST_HALT;
				else if (i_mov)
					next_state = ST_MOV;
				else if (i_alu || i_alui)
					next_state = ST_ALU0;
				else if (i_mvi)
					next_state = ST_MVI0;
				else if (i_inr || i_dcr)
					next_state = ST_INRDCR0;
				else if (i_lxi)
					next_state = ST_LXI0;
				else if (i_jmp || i_jcc)
					next_state = ST_JMP0;
				else if (i_lda || i_sta)
					next_state = ST_DIRECT0;
			end
			ST_MVI0: next_state = dst_m ? ST_MVI1 : ST_FETCH;
			ST_ALU0: next_state = ST_ALU1;
			ST_INRDCR0: next_state = ST_INRDCR1;
			ST_LXI0: next_state = ST_LXI1;
			ST_JMP0: next_state = ST_JMP1;
			ST_DIRECT0: next_state = ST_DIRECT1;
			ST_DIRECT1: next_state = ST_DIRECT2;
			ST_HALT: next_state = ST_HALT; // left only through reset.
			default: next_state = ST_FETCH;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FETCH;
			ir <= '0;
		end else if (ctrl.step) begin
			state <= next_state;
			if (state == ST_FETCH)
				ir <= memory_rdata;
		end
	end

	always_comb begin
		memory_read = 1'b0;
		memory_write = 1'b0;
		ctrl.addr_sel = ADDR_PC;
		ctrl.db_src = DB_NONE;
		ctrl.db_dst = DB_NONE;
		ctrl.alu_op = ALU_PASS;
		ctrl.set_flags = '0;
		ctrl.pc_inc = 1'b0;
		ctrl.pc_load = 1'b0;
		case (state)
			ST_FETCH: begin
				memory_read = 1'b1;
				ctrl.pc_inc = 1'b1;
			end
			ST_MOV: begin
				ctrl.addr_sel = ADDR_HL;
				memory_read = src_m;
				memory_write = dst_m;
				ctrl.db_src = reg_code(ir.mv.src);
				ctrl.db_dst = reg_code(ir.mv.dst);
			end
			ST_MVI0, ST_LXI0, ST_LXI1, ST_JMP0, ST_DIRECT0, ST_DIRECT1: begin
				memory_read = 1'b1;
				ctrl.pc_inc = 1'b1;
				ctrl.db_src = DB_MEM;
				case (state)
					ST_MVI0: ctrl.db_dst = dst_m ? DB_OPND : reg_code(ir.mv.dst);
					ST_LXI0: ctrl.db_dst = db_sel_t'({2'b01, ir.pr.pair, 1'b1});
					ST_LXI1: ctrl.db_dst = db_sel_t'({2'b01, ir.pr.pair, 1'b0});
					ST_DIRECT1: ctrl.db_dst = DB_ALH;
					default: ctrl.db_dst = DB_ALL;
				endcase
			end
			ST_MVI1: begin
				ctrl.addr_sel = ADDR_HL;
				memory_write = 1'b1;
				ctrl.db_src = DB_OPND;
			end
			ST_ALU0: begin
				ctrl.addr_sel = i_alui ? ADDR_PC : ADDR_HL;
				memory_read = i_alui || src_m;
				ctrl.pc_inc = i_alui;
				ctrl.db_src = i_alui ? DB_MEM : reg_code(ir.mv.src);
				ctrl.db_dst = DB_OPND;
			end
			ST_ALU1: begin
				ctrl.alu_op = alu_grp;
				ctrl.db_src = DB_ALU;
				ctrl.db_dst = (alu_grp == ALU_CMP) ? DB_NONE : DB_A;
				ctrl.set_flags = 8'hff;
			end
			ST_INRDCR0: begin
				ctrl.addr_sel = ADDR_HL;
				memory_read = dst_m;
				ctrl.db_src = reg_code(ir.mv.dst);
				ctrl.db_dst = DB_OPND;
			end
			ST_INRDCR1: begin
				ctrl.addr_sel = ADDR_HL;
				memory_write = dst_m;
				ctrl.alu_op = i_dcr ? ALU_DEC : ALU_INC;
				ctrl.db_src = DB_ALU;
				ctrl.db_dst = reg_code(ir.mv.dst);
				ctrl.set_flags = 8'hff;
				ctrl.set_flags[FLAG_C] = 1'b0; // INR and DCR keep carry.
			end
			ST_JMP1: begin
				memory_read = 1'b1;
				ctrl.db_src = DB_MEM;
				ctrl.db_dst = DB_ALH;
				ctrl.pc_load = taken;
				ctrl.pc_inc = !taken;
			end
			ST_DIRECT2: begin
				ctrl.addr_sel = ADDR_AL;
				memory_read = i_lda;
				memory_write = i_sta;
				ctrl.db_src = i_lda ? DB_MEM : DB_A;
				ctrl.db_dst = i_lda ? DB_A : DB_NONE;
			end
			default: ;
		endcase
	end

	// states without a request complete in one cycle.
	assign ctrl.step = !(memory_read || memory_write) || memory_done;
	assign cpu_fetch = state == ST_FETCH;
	assign cpu_halted = state == ST_HALT;

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic memory_read,
	output logic memory_write,
	output addr_t memory_addr,
	output data_t memory_wdata,
	input data_t memory_rdata,
	input logic memory_done,
	output logic cpu_fetch,
	output logic cpu_halted
);
	cpu_ctrl_if ctrl ();

	cpu_sequencer seq_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.memory_read(memory_read),
		.memory_write(memory_write),
		.cpu_fetch(cpu_fetch),
		.cpu_halted(cpu_halted)
	);

	cpu_datapath dp_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.memory_rdata(memory_rdata),
		.memory_addr(memory_addr),
		.memory_wdata(memory_wdata)
	);

endmodule

//--- testbench/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions import cpu_isa_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic memory_read,
	input logic memory_write,
	input addr_t memory_addr,
	input data_t memory_wdata,
	input logic memory_done,
	input logic cpu_fetch,
	input logic cpu_halted
);
	int unsigned fail_count = 0; // watched by the testbench top.

	one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(memory_read && memory_write))
		else begin
			fail_count++;
			$error("read and write requested in the same cycle");
		end

	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(memory_read && !memory_done) |=> (memory_read && $stable(memory_addr)))
		else begin
			fail_count++;
			$error("read request or its address changed before done");
		end

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		(memory_write && !memory_done) |=>
		(memory_write && $stable(memory_addr) && $stable(memory_wdata)))
		else begin
			fail_count++;
			$error("write request, address or data changed before done");
		end

	// the first cycle out of reset fetches from address zero.
	reset_fetch: assert property (@(posedge clk)
		$rose(rst_n) |-> (memory_read && cpu_fetch && !memory_write && !cpu_halted &&
		memory_addr == 16'h0000))
		else begin
			fail_count++;
			$error("no fetch from address zero after reset");
		end

	// an opcode fetch is always a plain read.
	fetch_reads: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_fetch |-> (memory_read && !memory_write && !cpu_halted))
		else begin
			fail_count++;
			$error("fetch state without a read request");
		end

	quiet_halt: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_halted |-> !(memory_read || memory_write))
		else begin
			fail_count++;
			$error("memory request while halted");
		end

endmodule

bind cpu_top cpu_assertions cpu_assertions_inst (
	.clk(clk),
	.rst_n(rst_n),
	.memory_read(memory_read),
	.memory_write(memory_write),
	.memory_addr(memory_addr),
	.memory_wdata(memory_wdata),
	.memory_done(memory_done),
	.cpu_fetch(cpu_fetch),
	.cpu_halted(cpu_halted)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_isa_pkg::*; ();
	localparam data_t val_x = 8'h3c;
	localparam data_t val_y = 8'h95;

	logic clk;
	logic rst_n;
	logic memory_read;
	logic memory_write;
	addr_t memory_addr;
	data_t memory_wdata;
	data_t memory_rdata = 8'h00;
	logic memory_done = 1'b0;
	logic cpu_fetch;
	logic cpu_halted;

	data_t mem [0:65535];
	addr_t load_addr = 16'h0000; // next free program byte.
	addr_t exp_addr [$];
	data_t exp_data [$];
	logic [15:0] lfsr = 16'd22203;
	logic busy = 1'b0;
	logic [1:0] wait_left = 2'd0;
	int instr_count = 0;
	int cycle_limit = 0;
	int cycles = 0;

	tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

	cpu_top cpu_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.memory_read(memory_read),
		.memory_write(memory_write),
		.memory_addr(memory_addr),
		.memory_wdata(memory_wdata),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.cpu_fetch(cpu_fetch),
		.cpu_halted(cpu_halted)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "run stopped on the first error");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		return s >> 1;
	endfunction

	function automatic logic [1:0] draw_wait();
		logic [1:0] w;
		w[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		w[1] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		return w;
	endfunction

	task automatic emit(input data_t b);
		mem[load_addr] = b;
		load_addr = load_addr + 16'd1;
	endtask

	task automatic instr1(input data_t op);
		emit(op);
		instr_count++;
	endtask

	task automatic instr2(input data_t op, input data_t imm);
		instr1(op);
		emit(imm);
	endtask

	task automatic instr3(input data_t op, input addr_t a);
		instr1(op);
		emit(a[7:0]);
		emit(a[15:8]);
	endtask

	task automatic expect_store(input addr_t a, input data_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic store_a(input addr_t a, input data_t d);
		instr3(8'h32, a);
		expect_store(a, d);
	endtask

	// a taken jump skips the second MVI, so the marker tells which path ran.
	task automatic jump_test(input data_t op, input logic taken, input addr_t mark);
		addr_t target;
		target = load_addr + 16'd7;
		instr2(8'h3e, 8'h4e);
		instr3(op, target);
		instr2(8'h3e, 8'h7a);
		store_a(mark, taken ? 8'h4e : 8'h7a);
	endtask

	task automatic check_store();
		if (exp_addr.size() == 0)
			report_failure($sformatf("store of %h to address %h with no store expected",
				memory_wdata, memory_addr));
		else if (memory_addr !== exp_addr[0])
			report_failure($sformatf("ERR memory_addr expected %h got %h",
				exp_addr[0], memory_addr));
		else if (memory_wdata !== exp_data[0])
			report_failure($sformatf("ERR memory_wdata expected %h got %h",
				exp_data[0], memory_wdata));
		else begin
			mem[memory_addr] = memory_wdata;
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
	endtask

	// done drops after the edge that took it, then the next request waits 0 to 3 cycles.
	task automatic serve_memory();
		if (memory_done) begin
			memory_done = 1'b0;
			busy = 1'b0;
		end
		if (memory_read || memory_write) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = draw_wait();
			end
			if (wait_left != 2'd0)
				wait_left = wait_left - 2'd1;
			else if (memory_write) begin
				check_store();
				memory_done = 1'b1;
			end else begin
				memory_rdata = mem[memory_addr];
				memory_done = 1'b1;
			end
		end
	endtask

	always @(negedge clk) begin
		cycles++;
		if (cpu_top_inst.cpu_assertions_inst.fail_count != 0)
			report_failure("a bus protocol assertion failed");
		else if (cycle_limit != 0 && cycles > cycle_limit)
			report_failure($sformatf("timeout, the CPU did not halt within %0d cycles",
				cycle_limit));
	end

	initial begin
		data_t a;
		data_t sum0;
		logic [8:0] t;
		logic fc, fz, fp, fs;
		for (int i = 0; i < 65536; i++)
			mem[i[15:0]] = i[15:8] ^ i[7:0];
		instr3(8'h21, 16'h2000); // LXI H.
		instr2(8'h3e, val_x);
		instr2(8'h06, val_y);
		instr1(8'h4f); // MOV C,A.
		instr1(8'h80); // ADD B.
		{fc, a} = {1'b0, val_x} + {1'b0, val_y};
		sum0 = a;
		store_a(16'h1000, a);
		instr1(8'h71); // MOV M,C.
		expect_store(16'h2000, val_x);
		instr1(8'h88); // ADC B.
		{fc, a} = {1'b0, a} + {1'b0, val_y} + {8'd0, fc};
		store_a(16'h1001, a);
		instr1(8'h98); // SBB B, where the top bit is the borrow.
		{fc, a} = {1'b0, a} - {1'b0, val_y} - {8'd0, fc};
		store_a(16'h1002, a);
		instr1(8'h90);
		t = {1'b0, a} - {1'b0, val_y};
		a = t[7:0];
		store_a(16'h1003, a);
		instr1(8'ha0);
		a = a & val_y;
		store_a(16'h1004, a);
		instr1(8'ha9);
		a = a ^ val_x;
		store_a(16'h1005, a);
		instr1(8'hb1);
		a = a | val_x;
		store_a(16'h1006, a);
		instr1(8'hb8); // CMP B keeps A.
		t = {1'b0, a} - {1'b0, val_y};
		store_a(16'h1007, a);
		fc = t[8];
		fz = t[7:0] == 8'h00;
		fp = ~^t[7:0];
		fs = t[7];
		jump_test(8'hda, fc, 16'h1010);
		jump_test(8'hc2, !fz, 16'h1011);
		jump_test(8'hea, fp, 16'h1012);
		jump_test(8'hfa, fs, 16'h1013);
		instr2(8'h3e, val_x);
		instr1(8'h91); // SUB C gives zero.
		t = {1'b0, val_x} - {1'b0, val_x};
		fc = t[8];
		fz = t[7:0] == 8'h00;
		fp = ~^t[7:0];
		fs = t[7];
		jump_test(8'hca, fz, 16'h1014);
		jump_test(8'hd2, !fc, 16'h1015);
		jump_test(8'he2, !fp, 16'h1016);
		jump_test(8'hf2, !fs, 16'h1017);
		jump_test(8'hc3, 1'b1, 16'h1018);
		instr2(8'h16, 8'hff);
		instr1(8'h14); // INR D wraps to zero.
		instr1(8'h7a);
		a = 8'hff + 8'h01;
		store_a(16'h1020, a);
		instr1(8'h3d);
		a = a - 8'h01;
		store_a(16'h1021, a);
		instr1(8'h34); // INR M.
		expect_store(16'h2000, val_x + 8'h01);
		instr3(8'h01, 16'h1234);
		instr3(8'h11, 16'h5678);
		instr1(8'h78);
		store_a(16'h1022, 8'h12);
		instr1(8'h7b);
		store_a(16'h1023, 8'h78);
		instr3(8'h3a, 16'h1000); // LDA, then ADI and ADD M.
		instr2(8'hc6, 8'h21);
		instr1(8'h86);
		a = sum0 + 8'h21 + (val_x + 8'h01);
		store_a(16'h1024, a);
		instr2(8'h36, 8'h5a);
		expect_store(16'h2000, 8'h5a);
		instr1(8'h5e);
		instr1(8'h7b);
		store_a(16'h1025, 8'h5a);
		instr1(8'h00);
		instr1(8'h76);
		cycle_limit = 40 * instr_count * 4; // an access takes four cycles at most.
		fork
			forever begin
				@(negedge clk);
				serve_memory();
			end
		join_none
		wait (cpu_halted);
		repeat (20) begin
			@(negedge clk);
			if (memory_read || memory_write)
				report_failure("memory request made after halt");
		end
		if (exp_addr.size() != 0)
			report_failure($sformatf("%0d expected stores never happened", exp_addr.size()));
		else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- verilog.f
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_ctrl_if.sv
src/cpu_alu_if.sv
src/cpu_alu.sv
src/cpu_datapath.sv
src/cpu_sequencer.sv
src/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/cpu_assertions.sv
testbench/tb_cpu.sv
